// File: vlog.f
hdl/scan_ctrl_pkg.sv
hdl/encoder_compare.sv
hdl/phase_timer.sv
hdl/scan_fsm.sv
hdl/actuator_ctrl.sv
hdl/finish_notifier.sv
hdl/scan_ctrl_top.sv
dv/tb_clk_gen.sv
dv/scan_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the scan sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module scan_ctrl_tb -o scan_sim \
    && ./obj_dir/scan_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// File: dv/scan_ctrl_tb.sv
`timescale 1ns/100ps

module scan_ctrl_tb import scan_ctrl_pkg::*; ();

    localparam int TIMEOUT_CYCLES   = 40;
    localparam int SETTLE_CYCLES    = 4;
    localparam int IDLE_WAIT_CYCLES = 20;
    localparam int ACK_WAIT_CYCLES  = 8;
    localparam int RESEND_MAX       = 2;
    localparam int SCEN_CYCLES      = 1500;   // upper bound for one scenario
    localparam int POST_CYCLES      = 40;     // lets resends and idle wait run out
    localparam int NUM_SCEN         = 8;
    localparam int FS_POS           = 1000;
    localparam int START_POS        = 2000;
    localparam int END_POS          = 3000;

    // injected faults, numbered after the code they should produce
    localparam int FLT_NONE       = 0;
    localparam int FLT_NO_OPEN    = 1;
    localparam int FLT_NO_FBC     = 2;
    localparam int FLT_EARLY      = 4;
    localparam int FLT_ENERGY     = 5;
    localparam int FLT_NO_TRIGGER = 6;

    logic clk, por_rst, tb_rst, rst;
    logic cmd, fs_state, fbc_state, fbc_state_err, ratio_err, fbc_sw, ack;
    logic [ENC_W-1:0] x_enc;
    logic [2:0] aurora_idle;
    logic fs_set, fs_en, fbc_close, fbc_open, gate, acc_on, fin_rep, err_rep, aur_rst;
    scan_err_t   err_code;
    scan_state_t state;

    // scenario under test and what the monitor saw
    bit sc_fbc, sc_ack;
    int sc_fault;
    int cyc, n_open, n_close, n_fbc_close, n_fbc_open, n_err, n_aur, n_rep;
    int fin_cyc;
    bit gate_in_scan;
    bit acc_seen;
    scan_state_t prev_state;
    scan_state_t path[$];
    int rep_cyc[$];
    event scen_end, cmp_done;

    assign rst = por_rst | tb_rst;

    tb_clk_gen u_clk (.clk_o(clk), .rst_o(por_rst));

    scan_ctrl_top #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES), .SETTLE_CYCLES(SETTLE_CYCLES),
        .IDLE_WAIT_CYCLES(IDLE_WAIT_CYCLES), .ACK_WAIT_CYCLES(ACK_WAIT_CYCLES),
        .RESEND_MAX(RESEND_MAX)
    ) dut_i (
        .clk_i(clk), .scan_soft_reset_i(rst), .scan_start_cmd_i(cmd),
        .x_encode_i(x_enc), .fast_shutter_encode_i(ENC_W'(FS_POS)),
        .x_start_encode_i(ENC_W'(START_POS)), .x_end_encode_i(ENC_W'(END_POS)),
        .fast_shutter_state_i(fs_state), .fbc_close_state_i(fbc_state),
        .fbc_close_state_err_i(fbc_state_err), .fbc_ratio_err_i(ratio_err),
        .scan_fbc_switch_i(fbc_sw), .aurora_tx_idle_i(aurora_idle),
        .scan_finish_comm_ack_i(ack),
        .fast_shutter_set_o(fs_set), .fast_shutter_en_o(fs_en),
        .fbc_close_loop_o(fbc_close), .fbc_open_loop_o(fbc_open),
        .real_scan_start_o(gate), .acc_force_on_o(acc_on),
        .scan_finish_comm_o(fin_rep), .scan_error_comm_o(err_rep),
        .aurora_scan_reset_o(aur_rst),
        .scan_error_comm_flag_o(err_code), .scan_state_o(state)
    );

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // expected outcome from the sequencer rules
    function automatic void expect_result(input int fault, input bit ack_on,
                                          output scan_state_t st, output scan_err_t code,
                                          output int reports);
        st      = (fault == FLT_NONE) ? ST_IDLE : ST_ERROR;
        reports = (fault != FLT_NONE) ? 0 : (ack_on ? 1 : 1 + RESEND_MAX);
        case (fault)
            FLT_NO_OPEN:    code = ERR_OPEN_TIMEOUT;
            FLT_NO_FBC:     code = ERR_FBC_TIMEOUT;
            FLT_EARLY:      code = ERR_SPINDLE_AHEAD;
            FLT_ENERGY:     code = ERR_ENERGY;
            FLT_NO_TRIGGER: code = ERR_NOT_TRIGGERED;
            default:        code = ERR_NONE;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // monitor, samples registered outputs mid-cycle
    ////////////////////////////////////////////////////
    always @(negedge clk) begin
        cyc <= cyc + 1;
        if (fs_en && !fs_set) n_open <= n_open + 1;
        if (fs_en && fs_set)  n_close <= n_close + 1;
        if (fbc_close)        n_fbc_close <= n_fbc_close + 1;
        if (fbc_open)         n_fbc_open <= n_fbc_open + 1;
        if (err_rep)          n_err <= n_err + 1;
        if (aur_rst)          n_aur <= n_aur + 1;
        if (acc_on)           acc_seen <= 1'b1;
        if (fin_rep) begin
            n_rep <= n_rep + 1;
            rep_cyc.push_back(cyc);
        end
        if (state == ST_SCAN && gate) gate_in_scan <= 1'b1;
        if (state != prev_state) begin
            path.push_back(state);
            if (state == ST_FINISH) fin_cyc <= cyc;
        end
        prev_state <= state;
    end

    ////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////
    always @(scen_end) begin
        scan_state_t exp_st;
        scan_err_t   exp_code;
        int          exp_rep;
        scan_state_t exp_path[$];
        expect_result(sc_fault, sc_ack, exp_st, exp_code, exp_rep);
        check("final state", 32'(state), 32'(exp_st));
        check("error code", 32'(err_code), 32'(exp_code));
        check("finish reports", n_rep, exp_rep);
        check("force-on at end", 32'(acc_on), 0);
        if (sc_fault == FLT_NONE) begin
            exp_path.delete();
            exp_path.push_back(ST_FS_WAIT);
            exp_path.push_back(ST_OPEN_SHUTTER);
            if (sc_fbc) exp_path.push_back(ST_FBC_CLOSE);
            exp_path.push_back(ST_SCAN);
            if (sc_fbc) exp_path.push_back(ST_FBC_OPEN);
            exp_path.push_back(ST_CLOSE_SHUTTER);
            exp_path.push_back(ST_FINISH);
            exp_path.push_back(ST_IDLE);
            check("state path length", path.size(), exp_path.size());
            foreach (exp_path[i]) check("state path step", 32'(path[i]), 32'(exp_path[i]));
            check("shutter open strobes", n_open, 1);
            check("shutter close strobes", n_close, 1);
            check("fbc close pulses", n_fbc_close, sc_fbc ? 1 : 0);
            check("fbc open pulses", n_fbc_open, sc_fbc ? 1 : 0);
            check("scan gate seen in scan", 32'(gate_in_scan), 1);
            check("force-on seen before scan", 32'(acc_seen), 1);
            check("first report delay", rep_cyc[0] - fin_cyc, 1);
            for (int i = 1; i < rep_cyc.size(); i++)
                check("resend spacing", rep_cyc[i] - rep_cyc[i-1], ACK_WAIT_CYCLES);
            check("aurora reset pulses", n_aur, sc_ack ? 0 : 1);
        end else begin
            check("error report pulses", n_err, 1);
        end
        ->cmp_done;
    end

    // one falling-edge step of the shutter, FBC, encoder and host models
    task automatic drive_step(inout logic [ENC_W-1:0] x, inout bit acked);
        int step;
        step = 1 + ($urandom % 8);
        if (fs_en)
            fs_state = fs_set || (sc_fault == FLT_NO_OPEN);
        if (fbc_close && sc_fault != FLT_NO_FBC) fbc_state = 1'b1;
        if (fbc_open) fbc_state = 1'b0;
        ratio_err = (sc_fault == FLT_ENERGY) && (state == ST_SCAN);
        if (sc_fault == FLT_EARLY && state == ST_FS_WAIT)
            x = START_POS + 500;   // jumps past scan start
        else if (state == ST_SCAN && sc_fault == FLT_NO_TRIGGER)
            x = END_POS + 500;
        else if (state == ST_SCAN && sc_fault != FLT_ENERGY)
            x = x + step;
        else if (x + step < START_POS - 500)
            x = x + step;          // park between shutter and start positions
        x_enc = x;
        ack = sc_ack && fin_rep && !acked;
        if (ack) acked = 1'b1;
    endtask

    task automatic run_scenario(input bit fbc_on, input int fault, input bit ack_on);
        logic [ENC_W-1:0] x;
        bit acked;
        int n;
        x     = ENC_W'(FS_POS - 32);   // close enough to reach the shutter position in time
        acked = 1'b0;
        n     = 0;
        @(negedge clk);
        tb_rst = 1'b1;
        x_enc = '0;
        fs_state = 1'b1;
        fbc_state = 1'b0;
        ratio_err = 1'b0;
        ack = 1'b0;
        fbc_sw = fbc_on;
        aurora_idle = ack_on ? 3'b111 : 3'b000;
        repeat (3) @(negedge clk);
        tb_rst = 1'b0;
        check("state after reset", 32'(state), 32'(ST_IDLE));
        check("error code after reset", 32'(err_code), 32'(ERR_NONE));
        @(posedge clk);
        sc_fbc = fbc_on;
        sc_fault = fault;
        sc_ack = ack_on;
        n_open = 0;
        n_close = 0;
        n_fbc_close = 0;
        n_fbc_open = 0;
        n_err = 0;
        n_aur = 0;
        n_rep = 0;
        gate_in_scan = 1'b0;
        acc_seen = 1'b0;
        path.delete();
        rep_cyc.delete();
        @(negedge clk);
        cmd = 1'b1;
        @(negedge clk);
        cmd = 1'b0;
        while (!(path.size() > 1 && state == ST_IDLE) && state != ST_ERROR) begin
            drive_step(x, acked);
            @(negedge clk);
            n++;
            if (n > SCEN_CYCLES) begin
                $display("scenario with fault %0d never reached idle or error", fault);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
        repeat (POST_CYCLES) begin
            drive_step(x, acked);
            @(negedge clk);
        end
        ->scen_end;
        @(cmp_done);
    endtask

    initial begin
        #((NUM_SCEN * (SCEN_CYCLES + POST_CYCLES + 10) + 100) * 10);
        $display("watchdog expired: the run took longer than all scenarios allow");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(77));
        tb_rst = 1'b0;
        cmd = 1'b0;
        x_enc = '0;
        fs_state = 1'b1;
        fbc_state = 1'b0;
        fbc_state_err = 1'b0;
        ratio_err = 1'b0;
        fbc_sw = 1'b0;
        ack = 1'b0;
        aurora_idle = 3'b000;
        cyc = 0;
        fin_cyc = 0;
        prev_state = ST_IDLE;
        wait (!por_rst);
        @(negedge clk);
        check("outputs after reset", 32'({fs_set, fs_en, fbc_close, fbc_open, gate, acc_on,
                                          fin_rep, err_rep, aur_rst}), 0);
        check("state after reset", 32'(state), 32'(ST_IDLE));
        check("error code after reset", 32'(err_code), 32'(ERR_NONE));
        run_scenario(1'b1, FLT_NONE, 1'b1);
        run_scenario(1'b0, FLT_NONE, 1'b1);
        run_scenario(1'b0, FLT_NONE, 1'b0);
        run_scenario(1'b0, FLT_NO_OPEN, 1'b1);
        run_scenario(1'b1, FLT_NO_FBC, 1'b1);
        run_scenario(1'b0, FLT_EARLY, 1'b1);
        run_scenario(1'b0, FLT_ENERGY, 1'b1);
        run_scenario(1'b0, FLT_NO_TRIGGER, 1'b1);
        // last fault case must come back to idle through reset
        @(negedge clk);
        tb_rst = 1'b1;
        repeat (3) @(negedge clk);
        tb_rst = 1'b0;
        check("state after final reset", 32'(state), 32'(ST_IDLE));
        check("error code after final reset", 32'(err_code), 32'(ERR_NONE));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: hdl/scan_ctrl_top.sv
`timescale 1ns/100ps

module scan_ctrl_top import scan_ctrl_pkg::*; #(
    parameter int TIMEOUT_CYCLES   = 100_000_000,  // 1 s at 100 MHz
    parameter int SETTLE_CYCLES    = 500_000,      // 5 ms
    parameter int IDLE_WAIT_CYCLES = 100_000_000,
    parameter int ACK_WAIT_CYCLES  = 100_000_000,
    parameter int RESEND_MAX       = 2
) (
    input  logic             clk_i,
    input  logic             scan_soft_reset_i,
    input  logic             scan_start_cmd_i,
    input  logic [ENC_W-1:0] x_encode_i,
    input  logic [ENC_W-1:0] fast_shutter_encode_i,
    input  logic [ENC_W-1:0] x_start_encode_i,
    input  logic [ENC_W-1:0] x_end_encode_i,
    input  logic             fast_shutter_state_i,   // 0 open, 1 closed
    input  logic             fbc_close_state_i,
    input  logic             fbc_close_state_err_i,
    input  logic             fbc_ratio_err_i,
    input  logic             scan_fbc_switch_i,
    input  logic [2:0]       aurora_tx_idle_i,
    input  logic             scan_finish_comm_ack_i,
    output logic             fast_shutter_set_o,
    output logic             fast_shutter_en_o,
    output logic             fbc_close_loop_o,
    output logic             fbc_open_loop_o,
    output logic             real_scan_start_o,
    output logic             acc_force_on_o,
    output logic             scan_finish_comm_o,
    output logic             scan_error_comm_o,
    output logic             aurora_scan_reset_o,
    output scan_err_t        scan_error_comm_flag_o,
    output scan_state_t      scan_state_o
);

    logic        shutter_cross, start_cross, start_edge, end_cross;
    logic        timeout, settled;
    logic        state_change, finish_entry;
    scan_state_t next_state;

    encoder_compare u_enc (
        .clk_i, .scan_soft_reset_i,
        .x_encode_i, .fast_shutter_encode_i, .x_start_encode_i, .x_end_encode_i,
        .shutter_cross_o (shutter_cross),
        .start_cross_o   (start_cross),
        .start_edge_o    (start_edge),
        .end_cross_o     (end_cross)
    );

    phase_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES), .SETTLE_CYCLES(SETTLE_CYCLES)) u_timer (
        .clk_i, .scan_soft_reset_i,
        .state_i        (scan_state_o),
        .state_change_i (state_change),
        .fast_shutter_state_i,
        .timeout_o      (timeout),
        .settled_o      (settled)
    );

    scan_fsm #(.IDLE_WAIT_CYCLES(IDLE_WAIT_CYCLES)) u_fsm (
        .clk_i, .scan_soft_reset_i, .scan_start_cmd_i,
        .shutter_cross_i   (shutter_cross),
        .start_cross_i     (start_cross),
        .end_cross_i       (end_cross),
        .timeout_i         (timeout),
        .settled_i         (settled),
        .real_scan_start_i (real_scan_start_o),
        .fast_shutter_state_i, .fbc_close_state_i, .fbc_close_state_err_i,
        .fbc_ratio_err_i, .scan_fbc_switch_i, .aurora_tx_idle_i,
        .state_o           (scan_state_o),
        .next_state_o      (next_state),
        .state_change_o    (state_change),
        .finish_entry_o    (finish_entry),
        .error_code_o      (scan_error_comm_flag_o),
        .error_entry_o     (),   // error report is built in actuator_ctrl
        .aurora_scan_reset_o
    );

    actuator_ctrl u_act (
        .clk_i, .scan_soft_reset_i,
        .state_i      (scan_state_o),
        .next_state_i (next_state),
        .start_edge_i (start_edge),
        .fast_shutter_set_o, .fast_shutter_en_o, .fbc_close_loop_o, .fbc_open_loop_o,
        .real_scan_start_o, .acc_force_on_o, .scan_error_comm_o
    );

    finish_notifier #(.ACK_WAIT_CYCLES(ACK_WAIT_CYCLES), .RESEND_MAX(RESEND_MAX)) u_notify (
        .clk_i, .scan_soft_reset_i,
        .finish_entry_i (finish_entry),
        .scan_finish_comm_ack_i,
        .scan_finish_comm_o
    );

endmodule

// File: hdl/finish_notifier.sv
`timescale 1ns/100ps

module finish_notifier import scan_ctrl_pkg::*; #(
    parameter int ACK_WAIT_CYCLES = 100_000_000,
    parameter int RESEND_MAX      = 2
) (
    input  logic clk_i,
    input  logic scan_soft_reset_i,
    input  logic finish_entry_i,
    input  logic scan_finish_comm_ack_i,
    output logic scan_finish_comm_o
);

    localparam int AW_W = $clog2(ACK_WAIT_CYCLES + 1);
    localparam int RS_W = $clog2(RESEND_MAX + 1);
    localparam logic [AW_W-1:0] AW_LAST = AW_W'(ACK_WAIT_CYCLES - 1);
    localparam logic [RS_W-1:0] RS_LAST = RS_W'(RESEND_MAX - 1);

    logic            wait_ack;
    logic [AW_W-1:0] wait_cnt;
    logic [RS_W-1:0] resend_cnt;
    logic            resend;

    // interval elapsed without an ack
    assign resend = wait_ack && !scan_finish_comm_ack_i && (wait_cnt == AW_LAST);

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            wait_ack           <= 1'b0;
            wait_cnt           <= '0;
            resend_cnt         <= '0;
            scan_finish_comm_o <= 1'b0;
        end else begin
            scan_finish_comm_o <= finish_entry_i || resend;
            if (finish_entry_i) begin
                wait_ack   <= 1'b1;
                wait_cnt   <= '0;
                resend_cnt <= '0;
            end else if (scan_finish_comm_ack_i || (resend && resend_cnt == RS_LAST)) begin
                wait_ack <= 1'b0;   // acked, or last resend gone out
                wait_cnt <= '0;
            end else if (wait_ack) begin
                wait_cnt <= resend ? '0 : wait_cnt + 1'b1;
                if (resend)
                    resend_cnt <= resend_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/actuator_ctrl.sv
`timescale 1ns/100ps

module actuator_ctrl import scan_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        scan_soft_reset_i,
    input  scan_state_t state_i,
    input  scan_state_t next_state_i,
    input  logic        start_edge_i,
    output logic        fast_shutter_set_o,   // 0 open, 1 close
    output logic        fast_shutter_en_o,
    output logic        fbc_close_loop_o,
    output logic        fbc_open_loop_o,
    output logic        real_scan_start_o,
    output logic        acc_force_on_o,
    output logic        scan_error_comm_o
);

    logic open_go;
    logic close_go;
    logic err_go;

    assign open_go  = (state_i == ST_FS_WAIT) && (next_state_i == ST_OPEN_SHUTTER);
    assign err_go   = (state_i != ST_ERROR) && (next_state_i == ST_ERROR);
    assign close_go = ((state_i != ST_CLOSE_SHUTTER) && (next_state_i == ST_CLOSE_SHUTTER))
                      || err_go;

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            fast_shutter_set_o <= 1'b0;
            fast_shutter_en_o  <= 1'b0;
            fbc_close_loop_o   <= 1'b0;
            fbc_open_loop_o    <= 1'b0;
            real_scan_start_o  <= 1'b0;
            acc_force_on_o     <= 1'b0;
            scan_error_comm_o  <= 1'b0;
        end else begin
            fast_shutter_en_o <= open_go || close_go;   // strobe, level held in set
            if (close_go)
                fast_shutter_set_o <= 1'b1;
            else if (open_go)
                fast_shutter_set_o <= 1'b0;
            fbc_close_loop_o  <= (state_i == ST_OPEN_SHUTTER) && (next_state_i == ST_FBC_CLOSE);
            fbc_open_loop_o   <= (state_i == ST_SCAN) && (next_state_i == ST_FBC_OPEN);
            scan_error_comm_o <= err_go;
            // scan gate follows the start edge, drops on leaving scan
            if (state_i == ST_SCAN && next_state_i != ST_SCAN)
                real_scan_start_o <= 1'b0;
            else if (state_i == ST_SCAN && start_edge_i)
                real_scan_start_o <= 1'b1;
            // stage held in force until the scan really starts
            if (err_go)
                acc_force_on_o <= 1'b0;
            else if (open_go)
                acc_force_on_o <= 1'b1;
            else if (state_i == ST_SCAN && start_edge_i)
                acc_force_on_o <= 1'b0;
        end
    end

endmodule

// File: hdl/scan_fsm.sv
`timescale 1ns/100ps

module scan_fsm import scan_ctrl_pkg::*; #(
    parameter int IDLE_WAIT_CYCLES = 100_000_000
) (
    input  logic        clk_i,
    input  logic        scan_soft_reset_i,
    input  logic        scan_start_cmd_i,
    input  logic        shutter_cross_i,
    input  logic        start_cross_i,
    input  logic        end_cross_i,
    input  logic        timeout_i,
    input  logic        settled_i,
    input  logic        real_scan_start_i,
    input  logic        fast_shutter_state_i,
    input  logic        fbc_close_state_i,
    input  logic        fbc_close_state_err_i,
    input  logic        fbc_ratio_err_i,
    input  logic        scan_fbc_switch_i,
    input  logic [2:0]  aurora_tx_idle_i,
    output scan_state_t state_o,
    output scan_state_t next_state_o,
    output logic        state_change_o,
    output logic        finish_entry_o,
    output scan_err_t   error_code_o,
    output logic        error_entry_o,
    output logic        aurora_scan_reset_o
);

    localparam int IW_W = $clog2(IDLE_WAIT_CYCLES + 1);
    localparam logic [IW_W-1:0] IW_LAST = IW_W'(IDLE_WAIT_CYCLES - 1);

    logic            armed;
    logic            spindle_ahead;
    logic            all_idle;
    logic            idle_hit;
    logic [IW_W-1:0] idle_cnt;
    scan_err_t       err_next;

    assign spindle_ahead  = armed && start_cross_i;
    assign all_idle       = &aurora_tx_idle_i;
    assign idle_hit       = idle_cnt == IW_LAST;
    assign state_change_o = state_o != next_state_o;
    assign error_entry_o  = (state_o != ST_ERROR) && (next_state_o == ST_ERROR);

    //////////////////////////////////////////////////
    // state register and arming
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            state_o <= ST_IDLE;
            armed   <= 1'b0;
        end else begin
            state_o <= next_state_o;
            if (scan_start_cmd_i)
                armed <= 1'b1;
            else if (state_o == ST_FINISH && next_state_o != ST_FINISH)
                armed <= 1'b0;   // one command, one scan
        end
    end

    //////////////////////////////////////////////////
    // next state and error cause
    //////////////////////////////////////////////////
    always_comb begin
        next_state_o = state_o;
        err_next     = ERR_NONE;
        case (state_o)
            ST_IDLE: if (armed) next_state_o = ST_FS_WAIT;
            ST_FS_WAIT: begin
                if (shutter_cross_i) begin
                    next_state_o = ST_OPEN_SHUTTER;
                end else if (spindle_ahead) begin
                    next_state_o = ST_ERROR;
                    err_next     = ERR_SPINDLE_AHEAD;
                end else if (timeout_i) begin
                    next_state_o = ST_ERROR;
                    err_next     = ERR_FS_WAIT_TO;
                end
            end
            ST_OPEN_SHUTTER: begin
                if (!fast_shutter_state_i && settled_i)
                    next_state_o = scan_fbc_switch_i ? ST_FBC_CLOSE : ST_SCAN;
                else if (spindle_ahead || timeout_i) begin
                    next_state_o = ST_ERROR;
                    err_next     = spindle_ahead ? ERR_SPINDLE_AHEAD : ERR_OPEN_TIMEOUT;
                end
            end
            ST_FBC_CLOSE: begin
                if (fbc_close_state_i)
                    next_state_o = ST_SCAN;
                else if (spindle_ahead || timeout_i) begin
                    next_state_o = ST_ERROR;
                    err_next     = spindle_ahead ? ERR_SPINDLE_AHEAD : ERR_FBC_TIMEOUT;
                end
            end
            ST_SCAN: begin
                if (end_cross_i && real_scan_start_i)
                    next_state_o = scan_fbc_switch_i ? ST_FBC_OPEN : ST_CLOSE_SHUTTER;
                else if (fbc_close_state_err_i || end_cross_i || fbc_ratio_err_i) begin
                    next_state_o = ST_ERROR;
                    if (fbc_close_state_err_i)      err_next = ERR_OSCILLATION;
                    else if (end_cross_i)           err_next = ERR_NOT_TRIGGERED;
                    else                            err_next = ERR_ENERGY;
                end
            end
            ST_FBC_OPEN: begin
                if (!fbc_close_state_i)
                    next_state_o = ST_CLOSE_SHUTTER;
                else if (timeout_i)
                    next_state_o = ST_ERROR;   // no own code, keeps previous
            end
            ST_CLOSE_SHUTTER: begin
                if (fast_shutter_state_i) begin
                    next_state_o = ST_FINISH;
                end else if (timeout_i) begin
                    next_state_o = ST_ERROR;
                    err_next     = ERR_CLOSE_TIMEOUT;
                end
            end
            ST_ERROR:  next_state_o = ST_ERROR;   // held until reset
            ST_FINISH: if (all_idle || idle_hit) next_state_o = ST_IDLE;
            default:   next_state_o = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // error code, finish entry, aurora idle wait
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            error_code_o        <= ERR_NONE;
            finish_entry_o      <= 1'b0;
            idle_cnt            <= '0;
            aurora_scan_reset_o <= 1'b0;
        end else begin
            if (error_entry_o && err_next != ERR_NONE)
                error_code_o <= err_next;
            finish_entry_o <= (state_o == ST_CLOSE_SHUTTER) && (next_state_o == ST_FINISH);
            if (state_o == ST_FINISH && !idle_hit)
                idle_cnt <= idle_cnt + 1'b1;
            else
                idle_cnt <= '0;
            aurora_scan_reset_o <= (state_o == ST_FINISH) && idle_hit && !all_idle;
        end
    end

endmodule

// File: hdl/phase_timer.sv
`timescale 1ns/100ps

module phase_timer import scan_ctrl_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 100_000_000,
    parameter int SETTLE_CYCLES  = 500_000
) (
    input  logic        clk_i,
    input  logic        scan_soft_reset_i,
    input  scan_state_t state_i,
    input  logic        state_change_i,
    input  logic        fast_shutter_state_i,
    output logic        timeout_o,
    output logic        settled_o
);

    localparam int TO_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int ST_W = $clog2(SETTLE_CYCLES + 1);
    localparam logic [TO_W-1:0] TO_LAST = TO_W'(TIMEOUT_CYCLES - 1);
    localparam logic [ST_W-1:0] ST_LAST = ST_W'(SETTLE_CYCLES - 1);

    logic [TO_W-1:0] to_cnt;
    logic [ST_W-1:0] settle_cnt;
    logic            timed_state;
    logic            shutter_open;

    assign timed_state = (state_i == ST_OPEN_SHUTTER) || (state_i == ST_FBC_CLOSE) ||
                         (state_i == ST_FBC_OPEN) || (state_i == ST_CLOSE_SHUTTER) ||
                         (state_i == ST_FS_WAIT);
    assign shutter_open = (state_i == ST_OPEN_SHUTTER) && !fast_shutter_state_i;

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i || state_change_i) begin
            to_cnt    <= '0;
            timeout_o <= 1'b0;   // no stale timeout into the next state
        end else begin
            if (timed_state && to_cnt != TO_LAST)
                to_cnt <= to_cnt + 1'b1;
            timeout_o <= timed_state && (to_cnt == TO_LAST);
        end
    end

    // shutter settle, restarts whenever the status drops
    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i || !shutter_open) begin
            settle_cnt <= '0;
            settled_o  <= 1'b0;
        end else begin
            if (settle_cnt != ST_LAST)
                settle_cnt <= settle_cnt + 1'b1;
            settled_o <= settle_cnt == ST_LAST;
        end
    end

endmodule

// File: hdl/encoder_compare.sv
`timescale 1ns/100ps

module encoder_compare import scan_ctrl_pkg::*; (
    input  logic             clk_i,
    input  logic             scan_soft_reset_i,
    input  logic [ENC_W-1:0] x_encode_i,
    input  logic [ENC_W-1:0] fast_shutter_encode_i,
    input  logic [ENC_W-1:0] x_start_encode_i,
    input  logic [ENC_W-1:0] x_end_encode_i,
    output logic             shutter_cross_o,
    output logic             start_cross_o,
    output logic             start_edge_o,
    output logic             end_cross_o
);

    logic shutter_raw;
    logic shutter_d0;
    logic start_d0, start_d1;

    assign shutter_raw   = x_encode_i >= fast_shutter_encode_i;
    assign start_cross_o = x_encode_i >= x_start_encode_i;   // used by error checks directly
    assign end_cross_o   = x_encode_i >= x_end_encode_i;

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            shutter_d0 <= 1'b0;
            start_d0   <= 1'b0;
            start_d1   <= 1'b0;
        end else begin
            shutter_d0 <= shutter_raw;
            start_d0   <= start_cross_o;
            start_d1   <= start_d0;
        end
    end

    // crossing flag, one cycle behind the encoder
    assign shutter_cross_o = shutter_d0;

    // first cycle the registered start flag is high
    assign start_edge_o = start_d0 & ~start_d1;

endmodule

// File: hdl/scan_ctrl_pkg.sv
package scan_ctrl_pkg;

    // encoder position width
    localparam int ENC_W = 32;

    //////////////////////////////////////////////////
    // sequencer states, numbering kept for host status
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_OPEN_SHUTTER  = 4'd1,
        ST_FBC_CLOSE     = 4'd2,
        ST_SCAN          = 4'd3,
        ST_FBC_OPEN      = 4'd4,
        ST_CLOSE_SHUTTER = 4'd5,
        ST_ERROR         = 4'd6,
        ST_FINISH        = 4'd7,
        ST_FS_WAIT       = 4'd9   // waiting for fast-shutter position
    } scan_state_t;

    //////////////////////////////////////////////////
    // error codes reported to the host
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ERR_NONE          = 4'd0,
        ERR_OPEN_TIMEOUT  = 4'd1,
        ERR_FBC_TIMEOUT   = 4'd2,
        ERR_CLOSE_TIMEOUT = 4'd3,
        ERR_SPINDLE_AHEAD = 4'd4,   // start position passed too early
        ERR_ENERGY        = 4'd5,
        ERR_NOT_TRIGGERED = 4'd6,
        ERR_OSCILLATION   = 4'd7,
        ERR_FS_WAIT_TO    = 4'd12
    } scan_err_t;

endpackage
